//--- spim_config.svh
`ifndef SPIM_CONFIG_SVH
`define SPIM_CONFIG_SVH

// Data and command word width
`define SPIM_WORD_W     32

// Command FIFO entries
`define SPIM_CMD_DEPTH  4

// SCLK divider field width
`define SPIM_DIV_W      8

// Number of chip selects, active low
`define SPIM_CS_N       4

`endif

//--- spim_pkg.sv
`include "spim_config.svh"

package spim_pkg;

    typedef logic [`SPIM_WORD_W-1:0]         spim_word_t;
    typedef logic [`SPIM_DIV_W-1:0]          spim_clkdiv_t;
    typedef logic [$clog2(`SPIM_WORD_W)-1:0] spim_bitcnt_t;
    typedef logic [`SPIM_CS_N-1:0]           spim_csn_t;

    // Opcode field, bits 31:28 of a command word
    typedef enum logic [3:0] {
        SPIM_OP_CFG  = 4'h1,
        SPIM_OP_SOT  = 4'h2,
        SPIM_OP_SEND = 4'h3,
        SPIM_OP_RECV = 4'h4,
        SPIM_OP_EOT  = 4'h5
    } spim_op_e;

    typedef struct packed {
        logic cpol;
        logic cpha;
    } spim_mode_t;

    // One shift job handed from decoder to shift engine
    typedef struct packed {
        logic         is_rx;
        logic         lsbfirst;
        spim_bitcnt_t bitcnt;
        spim_word_t   data;
    } spim_xfer_t;

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        WAIT_TX,
        RUN,
        DELIVER
    } spim_ctrl_state_e;

endpackage

//--- spim_cmd_fifo.sv
`timescale 1ns/1ps
`include "spim_config.svh"

module spim_cmd_fifo
(
    input  logic                 sys_clk_i,
    input  logic                 rst_n_i,

    input  spim_pkg::spim_word_t data_i,
    input  logic                 valid_i,
    output logic                 ready_o,

    output spim_pkg::spim_word_t data_o,
    output logic                 valid_o,
    input  logic                 ready_i
);

    import spim_pkg::*;

    localparam int DEPTH = `SPIM_CMD_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    spim_word_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign ready_o = (count_q != CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    always_ff @(posedge sys_clk_i)
    begin
        if (push)
            mem_q[wr_ptr_q] <= data_i;
    end

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

    a_count_bound : assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        count_q <= CNT_W'(DEPTH))
        else $error("spim_cmd_fifo: entry count above depth");

endmodule

//--- spim_ctrl.sv
`timescale 1ns/1ps

module spim_ctrl
(
    input  logic                   sys_clk_i,
    input  logic                   rst_n_i,

    input  spim_pkg::spim_word_t   cmd_i,
    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,

    input  spim_pkg::spim_word_t   tx_data_i,
    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,

    output spim_pkg::spim_word_t   rx_data_o,
    output logic                   rx_valid_o,
    input  logic                   rx_ready_i,

    output spim_pkg::spim_clkdiv_t clkdiv_o,
    output spim_pkg::spim_mode_t   mode_o,

    output logic                   xfer_start_o,
    output spim_pkg::spim_xfer_t   xfer_o,
    input  logic                   xfer_done_i,
    input  spim_pkg::spim_word_t   xfer_rx_data_i,

    output spim_pkg::spim_csn_t    spi_csn_o,
    output logic                   eot_o
);

    import spim_pkg::*;

    spim_ctrl_state_e state_q;
    spim_word_t       cmd_q;
    spim_op_e         op;
    spim_clkdiv_t     clkdiv_q;
    spim_mode_t       mode_q;
    spim_csn_t        csn_q;
    logic             eot_q;
    logic             start_q;
    spim_xfer_t       xfer_q;
    spim_word_t       rx_data_q;

    assign op = spim_op_e'(cmd_q[31:28]);

    assign cmd_ready_o  = (state_q == IDLE);
    assign tx_ready_o   = (state_q == WAIT_TX);
    assign rx_valid_o   = (state_q == DELIVER);
    assign rx_data_o    = rx_data_q;
    assign clkdiv_o     = clkdiv_q;
    assign mode_o       = mode_q;
    assign xfer_start_o = start_q;
    assign xfer_o       = xfer_q;
    assign spi_csn_o    = csn_q;
    assign eot_o        = eot_q;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q  <= IDLE;
            clkdiv_q <= '0;
            mode_q   <= '0;
            csn_q    <= '1;
            eot_q    <= 1'b0;
            start_q  <= 1'b0;
        end
        else
        begin
            eot_q   <= 1'b0;
            start_q <= 1'b0;
            case (state_q)
                IDLE:
                    if (cmd_valid_i)
                        state_q <= EXEC;
                EXEC:
                begin
                    state_q <= IDLE;
                    case (op)
                        SPIM_OP_CFG:
                        begin
                            clkdiv_q    <= cmd_q[7:0];
                            mode_q.cpol <= cmd_q[8];
                            mode_q.cpha <= cmd_q[9];
                        end
                        SPIM_OP_SOT:
                            csn_q <= ~(spim_csn_t'(1) << cmd_q[1:0]);
                        SPIM_OP_SEND:
                            state_q <= WAIT_TX;
                        SPIM_OP_RECV:
                        begin
                            start_q <= 1'b1;
                            state_q <= RUN;
                        end
                        SPIM_OP_EOT:
                        begin
                            csn_q <= '1;
                            eot_q <= 1'b1;
                        end
                        // Unknown opcodes are dropped
                        default:
                            state_q <= IDLE;
                    endcase
                end
                // No SCLK until the TX word shows up
                WAIT_TX:
                    if (tx_valid_i)
                    begin
                        start_q <= 1'b1;
                        state_q <= RUN;
                    end
                RUN:
                    if (xfer_done_i)
                        state_q <= xfer_q.is_rx ? DELIVER : IDLE;
                DELIVER:
                    if (rx_ready_i)
                        state_q <= IDLE;
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Transfer payload
    //////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (cmd_ready_o && cmd_valid_i)
            cmd_q <= cmd_i;
        if (state_q == EXEC)
        begin
            xfer_q.is_rx    <= (op == SPIM_OP_RECV);
            xfer_q.lsbfirst <= cmd_q[8];
            xfer_q.bitcnt   <= cmd_q[4:0];
            xfer_q.data     <= '0;
        end
        else if (tx_ready_o && tx_valid_i)
            xfer_q.data <= tx_data_i;
        if (state_q == RUN && xfer_done_i)
            rx_data_q <= xfer_rx_data_i;
    end

    a_one_csn : assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        $countones(~spi_csn_o) <= 1)
        else $error("spim_ctrl: more than one chip select active");

endmodule

//--- spim_clkgen.sv
`timescale 1ns/1ps

module spim_clkgen
(
    input  logic                   sys_clk_i,
    input  logic                   rst_n_i,

    input  spim_pkg::spim_clkdiv_t clkdiv_i,
    input  logic                   run_i,

    output logic                   lead_tick_o,
    output logic                   trail_tick_o
);

    import spim_pkg::*;

    spim_clkdiv_t cnt_q;
    logic         phase_q;
    logic         tick;

    // A tick every clkdiv+1 cycles, leading and trailing in turn
    assign tick         = run_i & (cnt_q == '0);
    assign lead_tick_o  = tick & ~phase_q;
    assign trail_tick_o = tick & phase_q;

    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q   <= '0;
            phase_q <= 1'b0;
        end
        else if (!run_i)
        begin
            // Preload so the first leading tick lands clkdiv+1 cycles in
            cnt_q   <= clkdiv_i;
            phase_q <= 1'b0;
        end
        else if (tick)
        begin
            cnt_q   <= clkdiv_i;
            phase_q <= ~phase_q;
        end
        else
            cnt_q <= cnt_q - 1'b1;
    end

endmodule

//--- spim_txrx.sv
`timescale 1ns/1ps

module spim_txrx
(
    input  logic                 sys_clk_i,
    input  logic                 rst_n_i,

    input  spim_pkg::spim_mode_t mode_i,

    input  logic                 xfer_start_i,
    input  spim_pkg::spim_xfer_t xfer_i,

    input  logic                 lead_tick_i,
    input  logic                 trail_tick_i,

    output logic                 busy_o,
    output logic                 xfer_done_o,
    output spim_pkg::spim_word_t rx_data_o,

    output logic                 spi_clk_o,
    output logic                 spi_sdo_o,
    input  logic                 spi_sdi_i
);

    import spim_pkg::*;

    logic         busy_q;
    logic         done_q;
    logic         sclk_q;
    logic         sdo_q;
    spim_bitcnt_t cnt_q;
    spim_bitcnt_t len_q;
    logic         lsbfirst_q;
    logic         is_rx_q;
    spim_word_t   tx_q;
    spim_word_t   rx_q;
    spim_bitcnt_t cur_idx;
    spim_bitcnt_t nxt_idx;
    logic         shift_tick;
    logic         sample_tick;
    logic         last_bit;

    // cnt_q is bits left minus one, so MSB first walks it straight down
    assign cur_idx  = lsbfirst_q ? len_q - cnt_q : cnt_q;
    assign nxt_idx  = lsbfirst_q ? cur_idx + 1'b1 : cur_idx - 1'b1;
    assign last_bit = (cnt_q == '0);

    assign shift_tick  = mode_i.cpha ? lead_tick_i : trail_tick_i;
    assign sample_tick = mode_i.cpha ? trail_tick_i : lead_tick_i;

    assign busy_o      = busy_q;
    assign xfer_done_o = done_q;
    assign rx_data_o   = rx_q;
    assign spi_clk_o   = sclk_q ^ mode_i.cpol;
    assign spi_sdo_o   = sdo_q;

    //////////////////////////////
    // SCLK and bit sequencing
    //////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (!rst_n_i)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            sclk_q <= 1'b0;
            sdo_q  <= 1'b0;
            cnt_q  <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (xfer_start_i)
            begin
                busy_q <= 1'b1;
                cnt_q  <= xfer_i.bitcnt;
                // First bit set up ahead of the first leading edge
                sdo_q  <= xfer_i.lsbfirst ? xfer_i.data[0] : xfer_i.data[xfer_i.bitcnt];
            end
            else if (busy_q)
            begin
                if (lead_tick_i)
                    sclk_q <= 1'b1;
                if (trail_tick_i)
                begin
                    sclk_q <= 1'b0;
                    if (last_bit)
                    begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                    else
                        cnt_q <= cnt_q - 1'b1;
                end
                // CPHA 1 drives the current bit, CPHA 0 moves on to the next
                if (shift_tick)
                begin
                    if (mode_i.cpha)
                        sdo_q <= tx_q[cur_idx];
                    else if (!last_bit)
                        sdo_q <= tx_q[nxt_idx];
                end
            end
        end
    end

    //////////////////////////////
    // Data registers
    //////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (xfer_start_i)
        begin
            tx_q       <= xfer_i.data;
            len_q      <= xfer_i.bitcnt;
            lsbfirst_q <= xfer_i.lsbfirst;
            is_rx_q    <= xfer_i.is_rx;
            rx_q       <= '0;
        end
        else if (busy_q && sample_tick && is_rx_q)
            rx_q[cur_idx] <= spi_sdi_i;
    end

    a_no_overlap : assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        xfer_start_i |-> !busy_q)
        else $error("spim_txrx: transfer started while busy");

endmodule

//--- spim_top.sv
`timescale 1ns/1ps

module spim_top
(
    input  logic                 sys_clk_i,
    input  logic                 rst_n_i,

    input  spim_pkg::spim_word_t cmd_i,
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,

    input  spim_pkg::spim_word_t tx_data_i,
    input  logic                 tx_valid_i,
    output logic                 tx_ready_o,

    output spim_pkg::spim_word_t rx_data_o,
    output logic                 rx_valid_o,
    input  logic                 rx_ready_i,

    output logic                 eot_o,

    output logic                 spi_clk_o,
    output spim_pkg::spim_csn_t  spi_csn_o,
    output logic                 spi_sdo_o,
    input  logic                 spi_sdi_i
);

    import spim_pkg::*;

    spim_word_t   fifo_cmd;
    logic         fifo_valid;
    logic         fifo_ready;
    spim_clkdiv_t clkdiv;
    spim_mode_t   mode;
    logic         xfer_start;
    spim_xfer_t   xfer;
    logic         xfer_done;
    spim_word_t   xfer_rx_data;
    logic         busy;
    logic         lead_tick;
    logic         trail_tick;

    spim_cmd_fifo u_cmd_fifo
    (
        .sys_clk_i ( sys_clk_i   ),
        .rst_n_i   ( rst_n_i     ),
        .data_i    ( cmd_i       ),
        .valid_i   ( cmd_valid_i ),
        .ready_o   ( cmd_ready_o ),
        .data_o    ( fifo_cmd    ),
        .valid_o   ( fifo_valid  ),
        .ready_i   ( fifo_ready  )
    );

    spim_ctrl u_ctrl
    (
        .sys_clk_i      ( sys_clk_i    ),
        .rst_n_i        ( rst_n_i      ),
        .cmd_i          ( fifo_cmd     ),
        .cmd_valid_i    ( fifo_valid   ),
        .cmd_ready_o    ( fifo_ready   ),
        .tx_data_i      ( tx_data_i    ),
        .tx_valid_i     ( tx_valid_i   ),
        .tx_ready_o     ( tx_ready_o   ),
        .rx_data_o      ( rx_data_o    ),
        .rx_valid_o     ( rx_valid_o   ),
        .rx_ready_i     ( rx_ready_i   ),
        .clkdiv_o       ( clkdiv       ),
        .mode_o         ( mode         ),
        .xfer_start_o   ( xfer_start   ),
        .xfer_o         ( xfer         ),
        .xfer_done_i    ( xfer_done    ),
        .xfer_rx_data_i ( xfer_rx_data ),
        .spi_csn_o      ( spi_csn_o    ),
        .eot_o          ( eot_o        )
    );

    spim_clkgen u_clkgen
    (
        .sys_clk_i    ( sys_clk_i  ),
        .rst_n_i      ( rst_n_i    ),
        .clkdiv_i     ( clkdiv     ),
        .run_i        ( busy       ),
        .lead_tick_o  ( lead_tick  ),
        .trail_tick_o ( trail_tick )
    );

    spim_txrx u_txrx
    (
        .sys_clk_i    ( sys_clk_i    ),
        .rst_n_i      ( rst_n_i      ),
        .mode_i       ( mode         ),
        .xfer_start_i ( xfer_start   ),
        .xfer_i       ( xfer         ),
        .lead_tick_i  ( lead_tick    ),
        .trail_tick_i ( trail_tick   ),
        .busy_o       ( busy         ),
        .xfer_done_o  ( xfer_done    ),
        .rx_data_o    ( xfer_rx_data ),
        .spi_clk_o    ( spi_clk_o    ),
        .spi_sdo_o    ( spi_sdo_o    ),
        .spi_sdi_i    ( spi_sdi_i    )
    );

endmodule

//--- tb_spim_clk.sv
`timescale 1ns/1ps

module tb_spim_clk
#(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
)
(
    output logic sys_clk_o,
    output logic rst_n_o
);

    initial
    begin
        sys_clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) sys_clk_o = ~sys_clk_o;
    end

    // Reset drops 1 ns after a rising edge, like every other input
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

//--- tb_spim.sv
`timescale 1ns/1ps

module tb_spim;

    import spim_pkg::*;

    localparam int CLK_NS  = 8;
    localparam int N_MODES = 4;
    localparam int N_XFER  = 4;
    localparam int DIV_MAX = 5;
    // Longest transfer is 32 bits of two half-periods, plus command and stall cycles
    localparam int XFER_CYC = 32 * 2 * (DIV_MAX + 1) + 80;
    localparam int WDOG_CYC = N_MODES * (N_XFER * XFER_CYC + 40) + 200;

    typedef struct packed {
        logic         is_rx;
        logic [5:0]   nbits;
        spim_clkdiv_t clkdiv;
        spim_word_t   bits;
    } expect_t;

    logic         sys_clk;
    logic         rst_n;
    spim_word_t   cmd;
    logic         cmd_valid;
    logic         cmd_ready;
    spim_word_t   tx_data;
    logic         tx_valid;
    logic         tx_ready;
    spim_word_t   rx_data;
    logic         rx_valid;
    logic         rx_ready;
    logic         eot;
    logic         spi_clk;
    spim_csn_t    spi_csn;
    logic         spi_sdo;
    logic         spi_sdi;

    logic         cfg_cpol;
    logic         cfg_cpha;
    spim_clkdiv_t cur_div;
    spim_word_t   slv_reply;
    spim_word_t   slv_bits;
    int           slv_nbits;
    int           slv_edges;
    time          slv_last_t;
    int           slv_half_min;
    int           slv_half_max;
    logic [15:0]  lfsr_q;
    expect_t      exp_q[$];
    spim_word_t   rx_got;
    logic         eot_prev;
    string        test_name;

    tb_spim_clk #(.PERIOD_NS(CLK_NS), .RST_CYCLES(8)) u_clk
    (
        .sys_clk_o ( sys_clk ),
        .rst_n_o   ( rst_n   )
    );

    spim_top i_dut
    (
        .sys_clk_i   ( sys_clk   ),
        .rst_n_i     ( rst_n     ),
        .cmd_i       ( cmd       ),
        .cmd_valid_i ( cmd_valid ),
        .cmd_ready_o ( cmd_ready ),
        .tx_data_i   ( tx_data   ),
        .tx_valid_i  ( tx_valid  ),
        .tx_ready_o  ( tx_ready  ),
        .rx_data_o   ( rx_data   ),
        .rx_valid_o  ( rx_valid  ),
        .rx_ready_i  ( rx_ready  ),
        .eot_o       ( eot       ),
        .spi_clk_o   ( spi_clk   ),
        .spi_csn_o   ( spi_csn   ),
        .spi_sdo_o   ( spi_sdo   ),
        .spi_sdi_i   ( spi_sdi   )
    );

    //////////////////////////////
    // Checks and helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_word(input string name, input spim_word_t exp, input spim_word_t act);
        if (act !== exp)
        begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_csn(input string name, input spim_csn_t exp, input spim_csn_t act);
        if (act !== exp)
        begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Chip select mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Level mismatch");
        end
    endtask

    // Chip select k low, every other one high
    function automatic spim_csn_t csn_for_select(input int k);
        spim_csn_t v;
        for (int i = 0; i < $bits(spim_csn_t); i++)
            v[i] = (i != k);
        return v;
    endfunction

    // Galois LFSR, taps for a 16-bit maximal sequence
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out)
            lfsr_q = lfsr_q ^ 16'hB400;
        return out;
    endfunction

    function automatic spim_word_t rand_bits(input int n);
        spim_word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // Send: bits on the wire, first bit highest. Receive: right-aligned word
    // built from the slave's stream, which starts at bit 31 of its reply
    function automatic spim_word_t ref_result(input logic is_rx, input logic lsb,
                                              input int n, input spim_word_t w);
        spim_word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            if (!is_rx)
                r = {r[30:0], lsb ? w[i] : w[n-1-i]};
            else if (lsb)
                r[i] = w[31-i];
            else
                r[n-1-i] = w[31-i];
        end
        return r;
    endfunction

    //////////////////////////////
    // SPI slave model
    //////////////////////////////

    always @(spi_clk)
    begin
        logic lead;
        int   half;
        if (rst_n === 1'b1 && spi_csn != '1)
        begin
            lead = (spi_clk != cfg_cpol);
            if (slv_edges > 0)
            begin
                half = int'(($time - slv_last_t) / CLK_NS);
                if (half < slv_half_min)
                    slv_half_min = half;
                if (half > slv_half_max)
                    slv_half_max = half;
            end
            slv_edges++;
            slv_last_t = $time;
            if (lead != cfg_cpha)
            begin
                slv_bits = {slv_bits[30:0], spi_sdo};
                slv_nbits++;
            end
            else if (cfg_cpha)
            begin
                spi_sdi = slv_reply[31];
                slv_reply = slv_reply << 1;
            end
            else
            begin
                slv_reply = slv_reply << 1;
                spi_sdi = slv_reply[31];
            end
        end
    end

    //////////////////////////////
    // Compare process
    //////////////////////////////

    // Mid-cycle sampling, all outputs settled
    always @(negedge sys_clk)
    begin
        expect_t e;
        if (rst_n === 1'b1)
        begin
            if (rx_valid && rx_ready)
                rx_got = rx_data;
            if (eot && eot_prev)
                abort_run("eot_o stayed high for more than one cycle");
            if (eot)
            begin
                if (exp_q.size() == 0)
                    abort_run("eot_o pulsed with no end command pending");
                e = exp_q.pop_front();
                check_csn("chip selects at eot", '1, spi_csn);
                check_word("bit count", spim_word_t'(e.nbits), spim_word_t'(slv_nbits));
                check_word("shortest half period", spim_word_t'(e.clkdiv) + 32'd1,
                           spim_word_t'(slv_half_min));
                check_word("longest half period", spim_word_t'(e.clkdiv) + 32'd1,
                           spim_word_t'(slv_half_max));
                if (e.is_rx)
                    check_word("received word", e.bits, rx_got);
                else
                    check_word("sent bits", e.bits, slv_bits);
            end
            eot_prev = eot;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic next_drive();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic push_cmd(input spim_word_t w);
        cmd = w;
        cmd_valid = 1'b1;
        @(negedge sys_clk);
        while (!cmd_ready)
            @(negedge sys_clk);
        next_drive();
        cmd_valid = 1'b0;
    endtask

    task automatic configure(input spim_clkdiv_t div, input logic cpol, input logic cpha);
        test_name = $sformatf("config div %0d mode %0d%0d", div, cpol, cpha);
        cfg_cpol = cpol;
        cfg_cpha = cpha;
        push_cmd({SPIM_OP_CFG, 18'b0, cpha, cpol, div});
        repeat (3) next_drive();
        check_bit("sclk idle level", cpol, spi_clk);
    endtask

    task automatic run_xfer(input logic is_rx, input logic stall);
        logic [1:0]   cs;
        logic         lsb;
        spim_bitcnt_t bc;
        spim_word_t   word;
        expect_t      e;
        cs   = 2'(rand_bits(2));
        lsb  = lfsr_bit();
        bc   = spim_bitcnt_t'(rand_bits(5));
        word = rand_bits(32);
        test_name = $sformatf("mode %0d%0d div %0d %s%s cs%0d n%0d", cfg_cpol, cfg_cpha,
                              cur_div, is_rx ? "recv" : "send", stall ? " stalled" : "",
                              cs, int'(bc) + 1);
        e.is_rx  = is_rx;
        e.nbits  = 6'(bc) + 6'd1;
        e.clkdiv = cur_div;
        e.bits   = ref_result(is_rx, lsb, int'(bc) + 1, word);
        exp_q.push_back(e);
        slv_reply    = word;
        slv_bits     = '0;
        slv_nbits    = 0;
        slv_edges    = 0;
        slv_half_min = 1 << 30;
        slv_half_max = 0;
        spi_sdi      = word[31];
        rx_ready     = !stall;

        push_cmd({SPIM_OP_SOT, 26'b0, cs});
        @(negedge sys_clk);
        while (spi_csn == '1)
            @(negedge sys_clk);
        check_csn("start selects one chip", csn_for_select(int'(cs)), spi_csn);
        next_drive();
        if (is_rx)
            push_cmd({SPIM_OP_RECV, 19'b0, lsb, 3'b0, bc});
        else
            push_cmd({SPIM_OP_SEND, 19'b0, lsb, 3'b0, bc});
        push_cmd({SPIM_OP_EOT, 28'b0});

        if (!is_rx)
        begin
            if (stall)
            begin
                @(negedge sys_clk);
                while (!tx_ready)
                    @(negedge sys_clk);
                repeat (12)
                begin
                    check_bit("sclk idle without tx data", cfg_cpol, spi_clk);
                    check_bit("tx_ready held", 1'b1, tx_ready);
                    @(negedge sys_clk);
                end
                next_drive();
            end
            tx_data  = word;
            tx_valid = 1'b1;
            @(negedge sys_clk);
            while (!tx_ready)
                @(negedge sys_clk);
            next_drive();
            tx_valid = 1'b0;
        end
        else if (stall)
        begin
            @(negedge sys_clk);
            while (!rx_valid)
                @(negedge sys_clk);
            repeat (10)
            begin
                check_bit("rx_valid held", 1'b1, rx_valid);
                check_csn("chip select held", csn_for_select(int'(cs)), spi_csn);
                check_word("word while stalled", e.bits, rx_data);
                @(negedge sys_clk);
            end
            next_drive();
            rx_ready = 1'b1;
        end

        @(negedge sys_clk);
        while (!eot)
            @(negedge sys_clk);
        next_drive();
        check_bit("sclk idle after transfer", cfg_cpol, spi_clk);
    endtask

    initial
    begin
        cmd          = '0;
        cmd_valid    = 1'b0;
        tx_data      = '0;
        tx_valid     = 1'b0;
        rx_ready     = 1'b1;
        spi_sdi      = 1'b0;
        cfg_cpol     = 1'b0;
        cfg_cpha     = 1'b0;
        cur_div      = '0;
        lfsr_q       = 16'd19213;
        eot_prev     = 1'b0;
        rx_got       = '0;
        slv_reply    = '0;
        slv_bits     = '0;
        slv_nbits    = 0;
        slv_edges    = 0;
        slv_last_t   = 0;
        slv_half_min = 0;
        slv_half_max = 0;
        test_name    = "reset";

        @(posedge rst_n);
        next_drive();
        check_csn("chip selects after reset", '1, spi_csn);
        check_bit("sclk after reset", 1'b0, spi_clk);
        check_bit("eot after reset", 1'b0, eot);
        check_bit("rx_valid after reset", 1'b0, rx_valid);
        check_bit("tx_ready after reset", 1'b0, tx_ready);
        check_bit("cmd_ready after reset", 1'b1, cmd_ready);

        // Every CPOL/CPHA pair, each with its own divider
        for (int m = 0; m < N_MODES; m++)
        begin
            cur_div = (m == 3) ? spim_clkdiv_t'(DIV_MAX) : spim_clkdiv_t'(m);
            configure(cur_div, m[1], m[0]);
            run_xfer(1'b0, 1'b0);
            run_xfer(1'b1, 1'b0);
            run_xfer(1'b0, 1'b1);
            run_xfer(1'b1, 1'b1);
        end

        repeat (4) next_drive();
        if (exp_q.size() != 0)
            abort_run("Some transfers never ended with an eot_o pulse");
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial
    begin
        #(WDOG_CYC * CLK_NS);
        $display("Timeout after %0d cycles, the DUT stopped responding", WDOG_CYC);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- compile.f
+incdir+.
spim_pkg.sv
spim_cmd_fifo.sv
spim_ctrl.sv
spim_clkgen.sv
spim_txrx.sv
spim_top.sv
tb_spim_clk.sv
tb_spim.sv
